//--- rtl/rv32_consts.svh
/*
 * Sizing constants for the RV32I execute core.
 * Include wherever queue depth, RAM size or the reset PC is needed.
 */
`ifndef RV32_CONSTS_SVH
`define RV32_CONSTS_SVH

// Instruction queue entries, also the credit count the fetch agent starts with
`define Q_DEPTH 4

// Width of the credit return count, enough to hold Q_DEPTH
`define CREDIT_W ($clog2(`Q_DEPTH + 1))

// Data RAM depth in 32-bit words and its word index width
`define DRAM_WORDS 64
`define DRAM_AW ($clog2(`DRAM_WORDS))

// First PC the fetch side issues after reset
`define RESET_PC 32'h0000_0000

`endif

//--- rtl/rv32_pkg.sv
/*
 * Shared types for the execute core: words, encodings, the instruction
 * union and the decode result. Import with rv32_pkg::* in module headers.
 */
package rv32_pkg;

  typedef logic [31:0] word_t;

  // Base opcodes that the stage implements
  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_AUIPC  = 7'b0010111,
    OP_JAL    = 7'b1101111,
    OP_JALR   = 7'b1100111,
    OP_BRANCH = 7'b1100011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_IMM    = 7'b0010011,
    OP_REG    = 7'b0110011,
    OP_SYSTEM = 7'b1110011
  } opcode_t;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
    ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU
  } alu_op_t;

  // Encoded as funct3, shared by loads and stores
  typedef enum logic [2:0] {
    LB = 3'b000, LH = 3'b001, LW = 3'b010, LBU = 3'b100, LHU = 3'b101
  } mem_type_t;

  typedef enum logic [2:0] {
    BEQ = 3'b000, BNE = 3'b001, BLT = 3'b100,
    BGE = 3'b101, BLTU = 3'b110, BGEU = 3'b111
  } br_type_t;

  // One instruction word, viewed in each base format
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2, rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      opcode_t    opcode;
    } r;
    struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      opcode_t     opcode;
    } i;
    struct packed {
      logic [6:0] imm_hi;
      logic [4:0] rs2, rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;
      opcode_t    opcode;
    } s;
    struct packed {
      logic       imm12;
      logic [5:0] imm10_5;
      logic [4:0] rs2, rs1;
      logic [2:0] funct3;
      logic [3:0] imm4_1;
      logic       imm11;
      opcode_t    opcode;
    } b;
    struct packed {
      logic [19:0] imm;
      logic [4:0]  rd;
      opcode_t     opcode;
    } u;
    struct packed {
      logic       imm20;
      logic [9:0] imm10_1;
      logic       imm11;
      logic [7:0] imm19_12;
      logic [4:0] rd;
      opcode_t    opcode;
    } j;
  } instr_u;

  typedef struct packed {
    word_t  pc;
    instr_u instr;
    logic   pred;
  } fe_entry_t;

  // Operand A select
  localparam logic [1:0] A_RS1  = 2'd0;
  localparam logic [1:0] A_PC   = 2'd1;
  localparam logic [1:0] A_ZERO = 2'd2;
  // Operand B select
  localparam logic B_RS2 = 1'b0;
  localparam logic B_IMM = 1'b1;
  // Register write data select
  localparam logic [1:0] WD_ALU  = 2'd0;
  localparam logic [1:0] WD_LOAD = 2'd1;
  localparam logic [1:0] WD_PC4  = 2'd2;

  typedef struct packed {
    logic [1:0] a_sel;
    logic       b_sel;
    logic [1:0] wd_sel;
    logic       reg_we;
    alu_op_t    alu_op;
    logic       mem_rd;
    logic       mem_wr;
    mem_type_t  mem_type;
    br_type_t   br_type;
    logic       branch;
    logic       jal;
    logic       jalr;
    logic       ecall;
    logic       illegal;
    word_t      imm;
  } ctrl_t;

endpackage

//--- rtl/fetch_execute_if.sv
/*
 * Queue head to execute stage link.
 * The queue offers an entry, the stage answers with pop and flush.
 */
`timescale 1ns/1ps

interface fetch_execute_if import rv32_pkg::*; ();

  // Head entry and its presence
  fe_entry_t entry;
  logic      valid;
  // Consumed this cycle
  logic      pop;
  // Drop every queued entry
  logic      flush;

  modport queue (
    output entry, valid,
    input  pop, flush
  );

  modport execute (
    input  entry, valid,
    output pop, flush
  );

endinterface

//--- rtl/instr_queue.sv
/*
 * Credit-tracked FIFO between the fetch agent and the execute stage.
 * Returns one credit per pop, or every held entry on a flush.
 */
`timescale 1ns/1ps
`include "rv32_consts.svh"

module instr_queue import rv32_pkg::*; (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 in_valid,
  input  fe_entry_t            in_entry,
  fetch_execute_if.queue       fe,
  output logic [`CREDIT_W-1:0] credit_return
);

  localparam int PW = (`Q_DEPTH > 1) ? $clog2(`Q_DEPTH) : 1;

  fe_entry_t            mem [`Q_DEPTH];
  logic [PW-1:0]        wr_ptr, rd_ptr;
  logic [`CREDIT_W-1:0] count;
  logic                 push, pop;

  // Wrap at Q_DEPTH so any depth works
  function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] p);
    return (p == PW'(`Q_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  // A push during flush is dropped
  assign push = in_valid && !fe.flush;
  assign pop  = fe.pop && fe.valid;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (fe.flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= next_ptr(wr_ptr);
      if (pop) rd_ptr <= next_ptr(rd_ptr);
      count <= count + `CREDIT_W'(push) - `CREDIT_W'(pop);
    end
  end

  // Entry storage
  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= in_entry;
  end

  assign fe.valid = (count != '0);
  assign fe.entry = mem[rd_ptr];

  // Flush hands back everything held plus the dropped push
  assign credit_return = fe.flush ? count + `CREDIT_W'(in_valid) : `CREDIT_W'(pop);

endmodule

//--- rtl/control_unit.sv
/*
 * RV32I decoder. Reads the format views of the instruction word and
 * produces operand selects, memory and flow controls and the immediate.
 */
`timescale 1ns/1ps

module control_unit import rv32_pkg::*; (
  input  instr_u instr,
  output ctrl_t  ctrl
);

  word_t      imm_i, imm_s, imm_b, imm_u, imm_j;
  logic [2:0] f3;
  logic [6:0] f7;

  assign f3 = instr.r.funct3;
  assign f7 = instr.r.funct7;

  // Immediates from each format with instr[31] as the sign bit
  assign imm_i = {{20{instr.i.imm[11]}}, instr.i.imm};
  assign imm_s = {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
  assign imm_b = {{19{instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
                  instr.b.imm10_5, instr.b.imm4_1, 1'b0};
  assign imm_u = {instr.u.imm, 12'b0};
  assign imm_j = {{11{instr.j.imm20}}, instr.j.imm20, instr.j.imm19_12,
                  instr.j.imm11, instr.j.imm10_1, 1'b0};

  // Maps funct3 to an ALU op where alt picks SUB or SRA
  function automatic alu_op_t alu_from_f3(input logic [2:0] f, input logic alt);
    case (f)
      3'b000:  return alt ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  always_comb begin
    ctrl          = '0;
    ctrl.a_sel    = A_RS1;
    ctrl.b_sel    = B_IMM;
    ctrl.wd_sel   = WD_ALU;
    ctrl.alu_op   = ALU_ADD;
    ctrl.mem_type = mem_type_t'(f3);
    ctrl.br_type  = br_type_t'(f3);
    ctrl.imm      = imm_i;
    case (instr.r.opcode)
      OP_LUI: begin
        ctrl.reg_we = 1'b1;
        ctrl.a_sel  = A_ZERO;
        ctrl.imm    = imm_u;
      end
      OP_AUIPC: begin
        ctrl.reg_we = 1'b1;
        ctrl.a_sel  = A_PC;
        ctrl.imm    = imm_u;
      end
      OP_JAL: begin
        ctrl.reg_we = 1'b1;
        ctrl.jal    = 1'b1;
        ctrl.wd_sel = WD_PC4;
        ctrl.imm    = imm_j;
      end
      OP_JALR: begin
        ctrl.reg_we  = 1'b1;
        ctrl.jalr    = 1'b1;
        ctrl.wd_sel  = WD_PC4;
        ctrl.illegal = (f3 != 3'b000);
      end
      OP_BRANCH: begin
        // Comparison runs in branch_res rather than the ALU
        ctrl.branch  = 1'b1;
        ctrl.b_sel   = B_RS2;
        ctrl.imm     = imm_b;
        ctrl.illegal = (f3 == 3'b010) || (f3 == 3'b011);
      end
      OP_LOAD: begin
        ctrl.reg_we  = 1'b1;
        ctrl.mem_rd  = 1'b1;
        ctrl.wd_sel  = WD_LOAD;
        ctrl.illegal = (f3 == 3'b011) || (f3[2:1] == 2'b11);
      end
      OP_STORE: begin
        ctrl.mem_wr  = 1'b1;
        ctrl.imm     = imm_s;
        ctrl.illegal = (f3 > 3'b010);
      end
      OP_IMM: begin
        ctrl.reg_we = 1'b1;
        ctrl.alu_op = alu_from_f3(f3, (f3 == 3'b101) && f7[5]);
        // Shift immediates carry funct7 in the upper bits
        if (f3 == 3'b001) ctrl.illegal = (f7 != 7'b0);
        else if (f3 == 3'b101) ctrl.illegal = (f7 != 7'b0) && (f7 != 7'b0100000);
      end
      OP_REG: begin
        ctrl.reg_we  = 1'b1;
        ctrl.b_sel   = B_RS2;
        ctrl.alu_op  = alu_from_f3(f3, f7[5]);
        ctrl.illegal = !((f7 == 7'b0) ||
                         ((f7 == 7'b0100000) && ((f3 == 3'b000) || (f3 == 3'b101))));
      end
      OP_SYSTEM: begin
        // ECALL is the only system instruction accepted
        ctrl.ecall   = (instr == 32'h0000_0073);
        ctrl.illegal = (instr != 32'h0000_0073);
      end
      default: ctrl.illegal = 1'b1;
    endcase
  end

endmodule

//--- rtl/alu.sv
/*
 * RV32I integer ALU. Purely combinational, shift amount is b[4:0].
 */
`timescale 1ns/1ps

module alu import rv32_pkg::*; (
  input  alu_op_t op,
  input  word_t   a,
  input  word_t   b,
  output word_t   y
);

  logic [4:0] shamt;

  assign shamt = b[4:0];

  always_comb begin
    case (op)
      ALU_ADD:  y = a + b;
      ALU_SUB:  y = a - b;
      ALU_AND:  y = a & b;
      ALU_OR:   y = a | b;
      ALU_XOR:  y = a ^ b;
      ALU_SLL:  y = a << shamt;
      ALU_SRL:  y = a >> shamt;
      // Arithmetic shift keeps the sign
      ALU_SRA:  y = word_t'($signed(a) >>> shamt);
      ALU_SLT:  y = {31'b0, $signed(a) < $signed(b)};
      ALU_SLTU: y = {31'b0, a < b};
      default:  y = a + b;
    endcase
  end

endmodule

//--- rtl/reg_file.sv
/*
 * Integer register file, two read ports and one write port.
 * x0 is hard-wired to zero, reads are combinational.
 */
`timescale 1ns/1ps

module reg_file import rv32_pkg::*; (
  input  logic       clk,
  input  logic       arst_n,
  input  logic [4:0] rs1,
  input  logic [4:0] rs2,
  output word_t      rs1_data,
  output word_t      rs2_data,
  input  logic       wen,
  input  logic [4:0] rd,
  input  word_t      wdata
);

  // No storage behind x0
  word_t regs [1:31];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 1; i < 32; i++) regs[i] <= '0;
    end else if (wen && (rd != 5'd0)) begin
      regs[rd] <= wdata;
    end
  end

  assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

//--- rtl/branch_res.sv
/*
 * Branch resolution: evaluates the condition and forms base plus offset.
 * The caller puts rs1 on pc for JALR so both targets share one adder.
 */
`timescale 1ns/1ps

module branch_res import rv32_pkg::*; (
  input  br_type_t br_type,
  input  word_t    rs1_data,
  input  word_t    rs2_data,
  input  word_t    pc,
  input  word_t    imm,
  output logic     taken,
  output word_t    target
);

  logic  eq, lt, ltu;
  word_t sum;

  assign eq  = (rs1_data == rs2_data);
  assign lt  = ($signed(rs1_data) < $signed(rs2_data));
  assign ltu = (rs1_data < rs2_data);

  always_comb begin
    case (br_type)
      BEQ:     taken = eq;
      BNE:     taken = !eq;
      BLT:     taken = lt;
      BGE:     taken = !lt;
      BLTU:    taken = ltu;
      BGEU:    taken = !ltu;
      default: taken = 1'b0;
    endcase
  end

  // Bit 0 is already zero for branch and JAL targets, JALR needs it cleared
  assign sum    = pc + imm;
  assign target = {sum[31:1], 1'b0};

endmodule

//--- rtl/lsu_align.sv
/*
 * Load/store lane logic for the data RAM. Builds byte enables, replicates
 * store data across lanes, extends loads and flags misaligned accesses.
 */
`timescale 1ns/1ps

module lsu_align import rv32_pkg::*; (
  input  mem_type_t  mem_type,
  input  word_t      addr,
  input  word_t      store_data,
  input  word_t      ram_rdata,
  output logic [3:0] byte_en,
  output word_t      wdata,
  output word_t      load_data,
  output logic       misaligned
);

  logic [1:0]  off;
  logic [7:0]  ld_byte;
  logic [15:0] ld_half;

  assign off = addr[1:0];

  // Pick the addressed lane out of the RAM word
  assign ld_byte = ram_rdata[{off, 3'b000} +: 8];
  assign ld_half = ram_rdata[{off[1], 4'b0000} +: 16];

  always_comb begin
    case (mem_type)
      LB, LBU: begin
        byte_en    = 4'b0001 << off;
        wdata      = {4{store_data[7:0]}};
        misaligned = 1'b0;
      end
      LH, LHU: begin
        byte_en    = off[1] ? 4'b1100 : 4'b0011;
        wdata      = {2{store_data[15:0]}};
        misaligned = off[0];
      end
      LW: begin
        byte_en    = 4'b1111;
        wdata      = store_data;
        misaligned = (off != 2'b00);
      end
      default: begin
        // Undefined widths are caught by the decoder
        byte_en    = 4'b0000;
        wdata      = store_data;
        misaligned = 1'b0;
      end
    endcase
  end

  always_comb begin
    case (mem_type)
      LB:      load_data = {{24{ld_byte[7]}}, ld_byte};
      LBU:     load_data = {24'b0, ld_byte};
      LH:      load_data = {{16{ld_half[15]}}, ld_half};
      LHU:     load_data = {16'b0, ld_half};
      default: load_data = ram_rdata;
    endcase
  end

endmodule

//--- rtl/data_ram.sv
/*
 * Internal data memory, word addressed, with byte lane writes at the
 * clock edge and combinational read.
 */
`timescale 1ns/1ps
`include "rv32_consts.svh"

module data_ram import rv32_pkg::*; (
  input  logic                clk,
  input  logic [`DRAM_AW-1:0] addr,
  input  word_t               wdata,
  input  logic [3:0]          be,
  input  logic                we,
  output word_t               rdata
);

  word_t mem [`DRAM_WORDS];

  // Only enabled lanes change
  always_ff @(posedge clk) begin
    if (we) begin
      for (int i = 0; i < 4; i++) begin
        if (be[i]) mem[addr][i*8 +: 8] <= wdata[i*8 +: 8];
      end
    end
  end

  assign rdata = mem[addr];

endmodule

//--- rtl/execute_stage.sv
/*
 * Single-cycle execute stage. Runs the head instruction, writes back,
 * resolves branches and jumps, and raises redirect, exceptions and halt.
 */
`timescale 1ns/1ps
`include "rv32_consts.svh"

module execute_stage import rv32_pkg::*; (
  input  logic                clk,
  input  logic                arst_n,
  fetch_execute_if.execute    fe,
  output logic [`DRAM_AW-1:0] ram_addr,
  output word_t               ram_wdata,
  output logic [3:0]          ram_be,
  output logic                ram_we,
  input  word_t               ram_rdata,
  output logic                redirect_valid,
  output word_t               redirect_addr,
  output logic                wb_valid,
  output logic [4:0]          wb_rd,
  output word_t               wb_data,
  output logic                exc_valid,
  output logic                exc_misaligned,
  output logic                exc_illegal,
  output logic                halt
);

  ctrl_t  ctrl;
  instr_u instr;
  word_t  pc, pc4, rs1_data, rs2_data, alu_a, alu_b, alu_y;
  word_t  br_base, br_target, load_data;
  logic   active, commit, br_taken, misaligned, take;

  assign instr  = fe.entry.instr;
  assign pc     = fe.entry.pc;
  assign pc4    = pc + 32'd4;
  // Head executes unless the core has halted
  assign active = fe.valid && !halt;

  control_unit i_cu (.instr(instr), .ctrl(ctrl));

  reg_file i_rf (
    .clk(clk), .arst_n(arst_n),
    .rs1(instr.r.rs1), .rs2(instr.r.rs2),
    .rs1_data(rs1_data), .rs2_data(rs2_data),
    .wen(wb_valid), .rd(instr.r.rd), .wdata(wb_data)
  );

  // Operand muxes
  always_comb begin
    case (ctrl.a_sel)
      A_RS1:   alu_a = rs1_data;
      A_PC:    alu_a = pc;
      default: alu_a = '0;
    endcase
  end
  assign alu_b = (ctrl.b_sel == B_IMM) ? ctrl.imm : rs2_data;

  alu i_alu (.op(ctrl.alu_op), .a(alu_a), .b(alu_b), .y(alu_y));

  // JALR adds to rs1 while branches and JAL add to pc
  assign br_base = ctrl.jalr ? rs1_data : pc;

  branch_res i_br (
    .br_type(ctrl.br_type), .rs1_data(rs1_data), .rs2_data(rs2_data),
    .pc(br_base), .imm(ctrl.imm), .taken(br_taken), .target(br_target)
  );

  lsu_align i_lsu (
    .mem_type(ctrl.mem_type), .addr(alu_y), .store_data(rs2_data),
    .ram_rdata(ram_rdata), .byte_en(ram_be), .wdata(ram_wdata),
    .load_data(load_data), .misaligned(misaligned)
  );

  // Exceptions suppress every write and the redirect
  assign exc_misaligned = active && (ctrl.mem_rd || ctrl.mem_wr) && misaligned;
  assign exc_illegal    = active && ctrl.illegal;
  assign exc_valid      = exc_misaligned || exc_illegal;
  assign commit         = active && !exc_valid;

  assign ram_addr = alu_y[`DRAM_AW+1:2];
  assign ram_we   = commit && ctrl.mem_wr;

  // Write-back
  assign wb_valid = commit && ctrl.reg_we;
  assign wb_rd    = instr.r.rd;
  always_comb begin
    case (ctrl.wd_sel)
      WD_LOAD: wb_data = load_data;
      WD_PC4:  wb_data = pc4;
      default: wb_data = alu_y;
    endcase
  end

  // Jumps always redirect and branches only on a wrong prediction
  assign take           = ctrl.jal || ctrl.jalr || (ctrl.branch && br_taken);
  assign redirect_valid = commit &&
                          (ctrl.jal || ctrl.jalr || (ctrl.branch && (br_taken != fe.entry.pred)));
  assign redirect_addr  = take ? br_target : pc4;

  assign fe.pop   = active;
  assign fe.flush = redirect_valid;

  // Halt latches on ECALL until reset
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) halt <= 1'b0;
    else if (commit && ctrl.ecall) halt <= 1'b1;
  end

endmodule

//--- rtl/exec_top.sv
/*
 * Top level of the execute core: instruction queue, execute stage and
 * data RAM. The fetch agent pushes while it holds credits.
 */
`timescale 1ns/1ps
`include "rv32_consts.svh"

module exec_top import rv32_pkg::*; (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 in_valid,
  input  word_t                in_pc,
  input  word_t                in_instr,
  input  logic                 in_pred,
  output logic [`CREDIT_W-1:0] credit_return,
  output logic                 redirect_valid,
  output word_t                redirect_addr,
  output logic                 wb_valid,
  output logic [4:0]           wb_rd,
  output word_t                wb_data,
  output logic                 exc_valid,
  output logic                 exc_misaligned,
  output logic                 exc_illegal,
  output logic                 halt
);

  fetch_execute_if     fe_if ();
  logic [`DRAM_AW-1:0] ram_addr;
  word_t               ram_wdata, ram_rdata;
  logic [3:0]          ram_be;
  logic                ram_we;

  // Entry packs as pc, instruction, prediction
  instr_queue i_queue (
    .clk(clk), .arst_n(arst_n), .in_valid(in_valid),
    .in_entry({in_pc, in_instr, in_pred}), .fe(fe_if.queue),
    .credit_return(credit_return)
  );

  execute_stage i_exec (
    .clk(clk), .arst_n(arst_n), .fe(fe_if.execute),
    .ram_addr(ram_addr), .ram_wdata(ram_wdata), .ram_be(ram_be),
    .ram_we(ram_we), .ram_rdata(ram_rdata),
    .redirect_valid(redirect_valid), .redirect_addr(redirect_addr),
    .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data),
    .exc_valid(exc_valid), .exc_misaligned(exc_misaligned),
    .exc_illegal(exc_illegal), .halt(halt)
  );

  data_ram i_dram (
    .clk(clk), .addr(ram_addr), .wdata(ram_wdata),
    .be(ram_be), .we(ram_we), .rdata(ram_rdata)
  );

endmodule

//--- testbench/tb_exec_top.sv
/*
 * Directed testbench for exec_top. A credit-tracking fetch agent pushes encoded
 * RV32I instructions, and reference registers and memory predict every commit.
 */
`timescale 1ns/1ps
`include "rv32_consts.svh"

module tb_exec_top import rv32_pkg::*; ();

  localparam int NUM_TESTS       = 6;
  localparam int CYCLES_PER_TEST = 200;
  localparam int CLK_PERIOD      = 20;

  logic                 clk, arst_n, in_valid, in_pred;
  word_t                in_pc, in_instr;
  logic [`CREDIT_W-1:0] credit_return;
  logic                 redirect_valid, wb_valid, exc_valid, exc_misaligned, exc_illegal, halt;
  word_t                redirect_addr, wb_data;
  logic [4:0]           wb_rd;

  // Agent and scoreboard state
  int          credits, pushes, returned, errors, checks;
  word_t       pc, rng;
  word_t       ref_regs [32];
  logic [7:0]  ref_mem [4*`DRAM_WORDS];
  logic [36:0] wb_q [$];
  word_t       redir_q [$];
  logic [1:0]  exc_q [$];

  exec_top i_dut (
    .clk(clk), .arst_n(arst_n), .in_valid(in_valid), .in_pc(in_pc),
    .in_instr(in_instr), .in_pred(in_pred), .credit_return(credit_return),
    .redirect_valid(redirect_valid), .redirect_addr(redirect_addr),
    .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data),
    .exc_valid(exc_valid), .exc_misaligned(exc_misaligned),
    .exc_illegal(exc_illegal), .halt(halt)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Outputs settle mid-cycle and are recorded at the falling edge
  always @(negedge clk) begin
    if (arst_n) begin
      credits  += credit_return;
      returned += credit_return;
      if (wb_valid) wb_q.push_back({wb_rd, wb_data});
      if (redirect_valid) redir_q.push_back(redirect_addr);
      if (exc_valid) exc_q.push_back({exc_misaligned, exc_illegal});
      assert (credits <= `Q_DEPTH) else begin
        errors++;
        $display("ERROR at %0t: more credits returned than were spent", $time);
      end
    end
  end

  // Watchdog sized from the test count
  initial begin
    #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
    $display("Watchdog expired at %0t, the DUT stopped responding", $time);
    $display("TEST FAILED");
    $finish;
  end

  function automatic word_t xorshift(input word_t x);
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  // One instruction encoder per base format
  function automatic word_t enc_r(input logic [6:0] f7, input logic [4:0] rs2, rs1,
                                  input logic [2:0] f3, input logic [4:0] rd,
                                  input logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  function automatic word_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                  input logic [2:0] f3, input logic [4:0] rd,
                                  input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic word_t enc_s(input logic [11:0] imm, input logic [4:0] rs2, rs1,
                                  input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
  endfunction

  function automatic word_t enc_b(input logic [12:0] imm, input logic [4:0] rs2, rs1,
                                  input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
  endfunction

  function automatic word_t enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
  endfunction

  function automatic word_t sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  // RV32I register-register result where alt marks SUB and SRA
  function automatic word_t ref_r(input logic [2:0] f3, input logic alt, input word_t a, b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3:    return (a < b) ? 32'd1 : 32'd0;
      3'd4:    return a ^ b;
      3'd5:    return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  // Little-endian byte gather followed by sign or zero extension from funct3
  function automatic word_t load_ref(input word_t addr, input logic [2:0] f3);
    word_t w;
    int    n;
    n = (f3[1:0] == 2'd0) ? 1 : (f3[1:0] == 2'd1) ? 2 : 4;
    w = '0;
    for (int i = 0; i < n; i++) w[i*8 +: 8] = ref_mem[addr + i];
    if (!f3[2] && n == 1) w = {{24{w[7]}}, w[7:0]};
    else if (!f3[2] && n == 2) w = {{16{w[15]}}, w[15:0]};
    return w;
  endfunction

  task automatic check_true(input logic cond, input string what);
    checks++;
    assert (cond) else begin
      errors++;
      $display("ERROR at %0t: %s", $time, what);
    end
  endtask

  task automatic check_val(input string name, input word_t got, input word_t exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("[FAIL] %0t %s: got %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic apply_reset();
    in_valid = 1'b0;
    arst_n   = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    arst_n   = 1'b1;
    credits  = `Q_DEPTH;
    pushes   = 0;
    returned = 0;
    pc       = `RESET_PC;
    foreach (ref_regs[i]) ref_regs[i] = '0;
    wb_q.delete();
    redir_q.delete();
    exc_q.delete();
    check_val("credit_return", credit_return, 0);
    check_val("halt", halt, 0);
    check_val("wb_valid", wb_valid, 0);
    check_val("redirect_valid", redirect_valid, 0);
    check_val("exc_valid", exc_valid, 0);
  endtask

  // Spends one credit and waits while none are held
  task automatic push(input word_t instr, input logic pred);
    while (credits == 0) begin
      @(posedge clk);
      #1;
    end
    in_valid = 1'b1;
    in_pc    = pc;
    in_instr = instr;
    in_pred  = pred;
    credits--;
    pushes++;
    pc += 4;
    @(posedge clk);
    #1;
    in_valid = 1'b0;
  endtask

  // Queue is empty once every credit is back
  task automatic drain();
    while (credits != `Q_DEPTH) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic run_instr(input word_t instr, input logic pred);
    push(instr, pred);
    drain();
  endtask

  task automatic expect_commit(input logic [4:0] rd, input word_t data);
    logic [36:0] e;
    if (wb_q.size() == 0) begin
      check_true(1'b0, "no write-back for an instruction that should commit");
    end else begin
      e = wb_q.pop_front();
      check_val("wb_rd", e[36:32], rd);
      check_val("wb_data", e[31:0], data);
    end
    if (rd != 5'd0) ref_regs[rd] = data;
  endtask

  task automatic expect_redirect(input word_t target);
    if (redir_q.size() == 0) begin
      check_true(1'b0, "no redirect for a taken jump or mispredicted branch");
    end else begin
      check_val("redirect_addr", redir_q.pop_front(), target);
    end
  endtask

  task automatic expect_exc(input logic mis, input logic ill);
    logic [1:0] e;
    if (exc_q.size() == 0) begin
      check_true(1'b0, "no exception raised");
    end else begin
      e = exc_q.pop_front();
      check_val("exc_misaligned", e[1], mis);
      check_val("exc_illegal", e[0], ill);
    end
  endtask

  // Nothing else may be left over from the instruction
  task automatic expect_quiet();
    check_true(wb_q.size() == 0, "write-back from an instruction that should not commit");
    check_true(redir_q.size() == 0, "unexpected redirect");
    check_true(exc_q.size() == 0, "unexpected exception");
    wb_q.delete();
    redir_q.delete();
    exc_q.delete();
  endtask

  task automatic exec_wb(input word_t instr, input word_t data);
    run_instr(instr, 1'b0);
    expect_commit(instr[11:7], data);
    expect_quiet();
  endtask

  // Random value built from LUI then ADDI
  task automatic set_reg(input logic [4:0] rd);
    rng = xorshift(rng);
    exec_wb({rng[31:12], rd, OP_LUI}, {rng[31:12], 12'b0});
    exec_wb(enc_i(rng[11:0], rd, 3'd0, rd, OP_IMM), ref_regs[rd] + sext12(rng[11:0]));
  endtask

  // Base register x20 holds 0x40
  task automatic store_op(input logic [2:0] f3, input logic [4:0] rs2, input logic [11:0] off);
    int n;
    n = (f3 == 3'd0) ? 1 : (f3 == 3'd1) ? 2 : 4;
    run_instr(enc_s(off, rs2, 5'd20, f3), 1'b0);
    expect_quiet();
    for (int i = 0; i < n; i++) ref_mem[32'h40 + off + i] = ref_regs[rs2][i*8 +: 8];
  endtask

  task automatic load_op(input logic [2:0] f3, input logic [4:0] rd, input logic [11:0] off);
    exec_wb(enc_i(off, 5'd20, f3, rd, OP_LOAD), load_ref(32'h40 + off, f3));
  endtask

  task automatic test_alu_ops();
    logic [2:0] f3s [10];
    logic       alts [10];
    f3s  = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
    alts = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
    set_reg(5'd1);
    set_reg(5'd2);
    for (int k = 0; k < 10; k++) begin
      exec_wb(enc_r(alts[k] ? 7'h20 : 7'h00, 5'd2, 5'd1, f3s[k], 5'(3 + k), OP_REG),
              ref_r(f3s[k], alts[k], ref_regs[1], ref_regs[2]));
    end
    // Write to x0 commits but leaves x0 reading zero
    exec_wb(enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd0, OP_REG), ref_regs[1] + ref_regs[2]);
    exec_wb(enc_r(7'h00, 5'd0, 5'd0, 3'd0, 5'd13, OP_REG), 32'd0);
  endtask

  task automatic test_credits();
    int start_ret;
    int start_push;
    start_ret  = returned;
    start_push = pushes;
    for (int i = 0; i < 20; i++) begin
      push(enc_i(12'd1, 5'd7, 3'd0, 5'd7, OP_IMM), 1'b0);
      // Each entry executes the cycle after its push and so only one is outstanding
      check_val("outstanding entries", (pushes - start_push) - (returned - start_ret), 1);
    end
    drain();
    check_val("credit_return sum", returned - start_ret, 20);
    for (int i = 0; i < 20; i++) expect_commit(5'd7, ref_regs[7] + 32'd1);
    expect_quiet();
  endtask

  task automatic test_branches();
    word_t target;
    word_t link;
    int    p0, r0;
    exec_wb(enc_i(12'd5, 5'd0, 3'd0, 5'd1, OP_IMM), 32'd5);
    exec_wb(enc_i(12'd5, 5'd0, 3'd0, 5'd2, OP_IMM), 32'd5);
    // Taken BEQ predicted not-taken flushes the filler behind it
    p0     = pushes;
    r0     = returned;
    target = pc + 32'd16;
    push(enc_b(13'd16, 5'd2, 5'd1, 3'd0), 1'b0);
    push(enc_i(12'd99, 5'd0, 3'd0, 5'd8, OP_IMM), 1'b0);
    drain();
    expect_redirect(target);
    expect_quiet();
    check_val("flushed credits", returned - r0, pushes - p0);
    pc = target;
    // JAL links pc+4 and always redirects
    target = pc + 32'd32;
    link   = pc + 32'd4;
    push(enc_j(21'd32, 5'd11), 1'b0);
    push(enc_i(12'd77, 5'd0, 3'd0, 5'd9, OP_IMM), 1'b0);
    drain();
    expect_commit(5'd11, link);
    expect_redirect(target);
    expect_quiet();
    pc = target;
    // Correctly predicted not-taken BNE and taken BGE
    run_instr(enc_b(13'd16, 5'd2, 5'd1, 3'd1), 1'b0);
    expect_quiet();
    run_instr(enc_b(13'd16, 5'd2, 5'd1, 3'd5), 1'b1);
    expect_quiet();
  endtask

  task automatic test_loads_stores();
    exec_wb(enc_i(12'h040, 5'd0, 3'd0, 5'd20, OP_IMM), 32'h40);
    set_reg(5'd21);
    set_reg(5'd22);
    // Byte lanes with a fresh word before each
    for (int off = 0; off < 4; off++) begin
      store_op(3'd2, 5'd21, 12'd0);
      store_op(3'd0, 5'd22, 12'(off));
      load_op(3'd2, 5'd23, 12'd0);
      load_op(3'd0, 5'd24, 12'(off));
      load_op(3'd4, 5'd25, 12'(off));
    end
    // Half lanes
    for (int off = 0; off < 4; off += 2) begin
      store_op(3'd2, 5'd21, 12'd4);
      store_op(3'd1, 5'd22, 12'(4 + off));
      load_op(3'd2, 5'd23, 12'd4);
      load_op(3'd1, 5'd24, 12'(4 + off));
      load_op(3'd5, 5'd25, 12'(4 + off));
    end
    store_op(3'd2, 5'd22, 12'd8);
    load_op(3'd2, 5'd23, 12'd8);
  endtask

  task automatic test_exceptions();
    store_op(3'd2, 5'd21, 12'd12);
    // Misaligned LW and SW
    run_instr(enc_i(12'd14, 5'd20, 3'd2, 5'd26, OP_LOAD), 1'b0);
    expect_exc(1'b1, 1'b0);
    expect_quiet();
    run_instr(enc_s(12'd14, 5'd22, 5'd20, 3'd2), 1'b0);
    expect_exc(1'b1, 1'b0);
    expect_quiet();
    // Custom-0 opcode is not RV32I
    run_instr(enc_r(7'h00, 5'd0, 5'd0, 3'd0, 5'd26, 7'b0001011), 1'b0);
    expect_exc(1'b0, 1'b1);
    expect_quiet();
    // RAM word and x26 untouched
    load_op(3'd2, 5'd27, 12'd12);
    exec_wb(enc_r(7'h00, 5'd0, 5'd26, 3'd0, 5'd28, OP_REG), ref_regs[26]);
  endtask

  task automatic test_halt();
    run_instr(32'h0000_0073, 1'b0);
    expect_quiet();
    check_val("halt", halt, 1);
    push(enc_i(12'd7, 5'd0, 3'd0, 5'd29, OP_IMM), 1'b0);
    push(enc_i(12'd8, 5'd0, 3'd0, 5'd29, OP_IMM), 1'b0);
    // Nothing may pop while halted
    repeat (10) @(posedge clk);
    #1;
    expect_quiet();
    check_val("credits held", credits, `Q_DEPTH - 2);
    check_val("halt", halt, 1);
    apply_reset();
    exec_wb(enc_i(12'd7, 5'd0, 3'd0, 5'd29, OP_IMM), 32'd7);
  endtask

  initial begin
    clk      = 1'b0;
    arst_n   = 1'b0;
    in_valid = 1'b0;
    in_pc    = '0;
    in_instr = '0;
    in_pred  = 1'b0;
    rng      = 32'd66755;
    errors   = 0;
    checks   = 0;
    credits  = `Q_DEPTH;
    pushes   = 0;
    returned = 0;
    apply_reset();
    test_alu_ops();
    test_credits();
    test_branches();
    test_loads_stores();
    test_exceptions();
    test_halt();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- vlog.f
+incdir+rtl
rtl/rv32_pkg.sv
rtl/fetch_execute_if.sv
rtl/instr_queue.sv
rtl/control_unit.sv
rtl/alu.sv
rtl/reg_file.sv
rtl/branch_res.sv
rtl/lsu_align.sv
rtl/data_ram.sv
rtl/execute_stage.sv
rtl/exec_top.sv
testbench/tb_exec_top.sv
